// File: cong_man_top.f
+incdir+source
source/cong_man_pkg.sv
source/table_port_if.sv
source/queue_state_table.sv
source/page_allocator.sv
source/admission_ctrl.sv
source/cong_man_top.sv
verif/cong_man_assertions.sv
verif/cong_man_tb.sv

// File: Makefile
# Verilator build and run of the congestion manager testbench

TOP := cong_man_tb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

# Pass only when the testbench prints its pass line
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f cong_man_top.f -Mdir $(OBJ) -o V$(TOP)
	@out="$$(./$(OBJ)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJ)

// File: verif/cong_man_tb.sv
/* Testbench for the admission stage: clock, reset, directed and random
   descriptors, reference model, decision checker and watchdog */

`include "cong_man_cfg.svh"

module cong_man_tb;
    import cong_man_pkg::*;

    typedef struct packed {
        logic         enq;
        queue_idx_t   queue;
        word_ptr_t    new_tail;
        logic         malloc;
        page_idx_t    page;
        drop_reason_t reason;
        page_cnt_t    free;
    } decision_t;

    logic         core_clk_ifc;
    logic         reset;
    logic         desc_valid;
    port_t        desc_port;
    prio_t        desc_prio;
    byte_len_t    desc_len;
    logic         desc_drop_mark;
    logic         thresh_wr_en;
    queue_idx_t   thresh_wr_queue;
    occ_t         thresh_wr_data;
    logic         enq_valid;
    queue_idx_t   enq_queue;
    word_ptr_t    enq_new_tail;
    logic         enq_malloc;
    page_idx_t    enq_page;
    logic         drop_valid;
    drop_reason_t drop_reason;
    page_cnt_t    num_free_pages;

    // Reference model of the queue tables and page pool
    int        model_occ    [NUM_QUEUES];
    int        model_thresh [NUM_QUEUES];
    int        model_tail   [NUM_QUEUES];
    int        model_page   [NUM_QUEUES];
    bit        model_open   [NUM_QUEUES];
    int        model_free;
    int        model_next;

    decision_t expected [$];
    int        sent_count;
    int        cycles;
    int        checks;
    int        errors;
    int        failed_tests;
    bit        hist0;
    bit        hist1;

    cong_man_top UUT (
        .core_clk_ifc    (core_clk_ifc),
        .reset           (reset),
        .desc_valid      (desc_valid),
        .desc_port       (desc_port),
        .desc_prio       (desc_prio),
        .desc_len        (desc_len),
        .desc_drop_mark  (desc_drop_mark),
        .thresh_wr_en    (thresh_wr_en),
        .thresh_wr_queue (thresh_wr_queue),
        .thresh_wr_data  (thresh_wr_data),
        .enq_valid       (enq_valid),
        .enq_queue       (enq_queue),
        .enq_new_tail    (enq_new_tail),
        .enq_malloc      (enq_malloc),
        .enq_page        (enq_page),
        .drop_valid      (drop_valid),
        .drop_reason     (drop_reason),
        .num_free_pages  (num_free_pages)
    );

    always #5 core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////
    // Reference model

    function automatic decision_t predict_decision(input int port, input int prio,
                                                   input int len, input bit mark);
        decision_t d;
        int        q;
        int        words;
        bit        malloc;
        d      = '0;
        q      = port * `CM_QUEUES_PER_PORT + ((prio >= `CM_PRIO_SPLIT) ? 1 : 0);
        words  = (len + `CM_WORD_BYTES - 1) / `CM_WORD_BYTES;
        malloc = !model_open[q] || (model_tail[q] + words >= WORDS_PER_PAGE);
        if (len + model_occ[q] > model_thresh[q]) begin
            d.reason = QUEUE_FULL;
        end else if (mark && (prio < `CM_POLICER_PRIO)) begin
            d.reason = POLICER;
        end else if (malloc && (model_occ[q] / `CM_PAGE_BYTES > model_free)) begin
            d.reason = OCC_EXCEEDS_FREE;
        end else if (malloc && (model_free == 0)) begin
            d.reason = NO_PAGES;
        end else begin
            d.enq         = 1'b1;
            model_occ[q]  = model_occ[q] + len;
            model_tail[q] = (model_tail[q] + words) % WORDS_PER_PAGE;
            if (malloc) begin
                model_page[q] = model_next;
                model_open[q] = 1'b1;
                model_next    = model_next + 1;
                model_free    = model_free - 1;
            end
            d.queue    = queue_idx_t'(q);
            d.new_tail = word_ptr_t'(model_tail[q]);
            d.malloc   = malloc;
            d.page     = page_idx_t'(model_page[q]);
        end
        d.free = page_cnt_t'(model_free);
        return d;
    endfunction

    ////////////////////////////////////////
    // Stimulus

    task automatic apply_reset();
        @(posedge core_clk_ifc);
        reset        <= 1'b1;
        desc_valid   <= 1'b0;
        thresh_wr_en <= 1'b0;
        repeat (4) @(posedge core_clk_ifc);
        reset <= 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            model_occ[q]    = 0;
            model_thresh[q] = MEM_BYTES;
            model_tail[q]   = 0;
            model_page[q]   = 0;
            model_open[q]   = 1'b0;
        end
        model_free = `CM_NUM_PAGES;
        model_next = 0;
    endtask

    task automatic send_desc(input int port, input int prio, input int len, input bit mark);
        @(posedge core_clk_ifc);
        desc_valid     <= 1'b1;
        desc_port      <= port_t'(port);
        desc_prio      <= prio_t'(prio);
        desc_len       <= byte_len_t'(len);
        desc_drop_mark <= mark;
        expected.push_back(predict_decision(port, prio, len, mark));
        sent_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge core_clk_ifc);
            desc_valid <= 1'b0;
        end
    endtask

    // Waits for every outstanding decision to reach the checker
    task automatic drain();
        idle_cycles(1);
        while (expected.size() != 0) begin
            @(posedge core_clk_ifc);
        end
        idle_cycles(2);
    endtask

    task automatic write_thresh(input int q, input int value);
        @(posedge core_clk_ifc);
        thresh_wr_en    <= 1'b1;
        thresh_wr_queue <= queue_idx_t'(q);
        thresh_wr_data  <= occ_t'(value);
        model_thresh[q] = value;
        @(posedge core_clk_ifc);
        thresh_wr_en <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks

    task automatic check_value(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic compare_decision(input decision_t want);
        check_value("enq_valid", int'(enq_valid), int'(want.enq));
        if (want.enq && enq_valid) begin
            check_value("enq_queue", int'(enq_queue), int'(want.queue));
            check_value("enq_new_tail", int'(enq_new_tail), int'(want.new_tail));
            check_value("enq_malloc", int'(enq_malloc), int'(want.malloc));
            check_value("enq_page", int'(enq_page), int'(want.page));
        end else if (!want.enq && drop_valid) begin
            check_value("drop_reason", int'(drop_reason), int'(want.reason));
        end
        check_value("num_free_pages", int'(num_free_pages), int'(want.free));
    endtask

    // Outputs are sampled mid cycle, two cycles after the descriptor
    initial begin : compare_outputs
        bit        due;
        decision_t want;
        hist0 = 1'b0;
        hist1 = 1'b0;
        forever begin
            @(negedge core_clk_ifc);
            due   = hist1;
            hist1 = hist0;
            hist0 = desc_valid;
            if (due) begin
                check_true(enq_valid || drop_valid, "descriptor got no decision pulse");
                check_true(!(enq_valid && drop_valid), "enq and drop pulsed together");
                if (expected.size() != 0) begin
                    want = expected.pop_front();
                    if (enq_valid || drop_valid) begin
                        compare_decision(want);
                    end
                end
            end else if (enq_valid || drop_valid) begin
                check_true(1'b0, "decision pulse without a descriptor");
            end
        end
    end

    ////////////////////////////////////////
    // Tests

    task automatic run_threshold_test();
        apply_reset();
        write_thresh(0, 16384);
        write_thresh(1, 8192);
        // Land exactly on the threshold, then one byte over
        for (int i = 0; i < 16; i++) begin
            send_desc(0, 1, 1024, 1'b0);
        end
        send_desc(0, 2, 1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            send_desc(0, 6, 1024, 1'b0);
        end
        send_desc(0, 7, 1, 1'b0);
        drain();
    endtask

    task automatic run_policer_test();
        apply_reset();
        for (int i = 0; i < 40; i++) begin
            send_desc($urandom_range(3, 0), $urandom_range(7, 0), $urandom_range(512, 64),
                      ($urandom_range(1, 0) == 1));
        end
        drain();
    endtask

    task automatic run_page_order_test();
        apply_reset();
        // First packet of each queue opens a page
        for (int q = 0; q < NUM_QUEUES; q++) begin
            send_desc(q / 2, (q % 2) * 6, $urandom_range(1500, 1), 1'b0);
        end
        drain();
        check_value("num_free_pages after first packets", int'(num_free_pages), 56);
        for (int i = 0; i < 16; i++) begin
            send_desc((i % 8) / 2, (i % 2) * 6, $urandom_range(1500, 300), 1'b0);
        end
        drain();
    endtask

    task automatic run_exhaustion_test();
        apply_reset();
        // Bulk of the pool through six queues, one page per packet
        for (int r = 0; r < 9; r++) begin
            for (int q = 0; q < 6; q++) begin
                send_desc(q / 2, (q % 2) * 6, 1024, 1'b0);
            end
        end
        // Last ten pages through two queues holding one-byte packets
        for (int i = 0; i < 64; i++) begin
            send_desc(3, 0, 1, 1'b0);
            send_desc(3, 7, 1, 1'b0);
        end
        drain();
        check_value("num_free_pages after exhaustion", int'(num_free_pages), 0);
        send_desc(3, 0, 961, 1'b0);
        send_desc(3, 7, 1024, 1'b0);
        // Still fit in the open page
        send_desc(3, 0, 1, 1'b0);
        send_desc(0, 0, 1, 1'b0);
        drain();
    endtask

    task automatic run_random_test();
        int port;
        apply_reset();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            write_thresh(q, $urandom_range(40000, 2000));
        end
        for (int i = 0; i < 300; i++) begin
            // Mostly two ports so queues repeat back to back
            port = ($urandom_range(3, 0) == 0) ? $urandom_range(3, 0) : $urandom_range(1, 0);
            send_desc(port, $urandom_range(7, 0), $urandom_range(1500, 1),
                      ($urandom_range(3, 0) == 0));
            if ($urandom_range(1, 0) == 1) begin
                idle_cycles($urandom_range(2, 1));
            end
        end
        drain();
        check_value("final num_free_pages", int'(num_free_pages), model_free);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin : main
        int mark;
        core_clk_ifc    = 1'b0;
        reset           = 1'b1;
        desc_valid      = 1'b0;
        desc_port       = '0;
        desc_prio       = '0;
        desc_len        = '0;
        desc_drop_mark  = 1'b0;
        thresh_wr_en    = 1'b0;
        thresh_wr_queue = '0;
        thresh_wr_data  = '0;
        void'($urandom(32'h852af087));
        mark = errors;
        run_threshold_test();
        end_test("queue threshold", mark);
        mark = errors;
        run_policer_test();
        end_test("policer", mark);
        mark = errors;
        run_page_order_test();
        end_test("page order", mark);
        mark = errors;
        run_exhaustion_test();
        end_test("page exhaustion", mark);
        mark = errors;
        run_random_test();
        end_test("random mix", mark);
        $display("tests: 5, failed: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Limit grows with every descriptor sent
    initial begin : watchdog
        cycles = 0;
        while (cycles <= 20 * sent_count + 1000) begin
            @(posedge core_clk_ifc);
            cycles++;
        end
        $display("Timeout: no progress after %0d cycles, %0d descriptors sent",
                 cycles, sent_count);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verif/cong_man_assertions.sv
/* Concurrent checks on the admission controller decision strobes
   and page allocation requests, bound into admission_ctrl */

module cong_man_assertions (
    input logic                    core_clk_ifc,
    input logic                    reset,
    input logic                    desc_valid,
    input logic                    enq_valid,
    input logic                    drop_valid,
    input logic                    alloc,
    input cong_man_pkg::page_cnt_t free_pages
);

    ////////////////////////////////////////
    // Decision strobes

    enq_drop_exclusive: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        !(enq_valid && drop_valid)
    ) else $error("enq_valid and drop_valid high in the same cycle");

    // Decision lands two edges after the descriptor is sampled
    desc_gets_decision: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        desc_valid |-> ##2 (enq_valid || drop_valid)
    ) else $error("descriptor without a decision two cycles later");

    decision_has_desc: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        (enq_valid || drop_valid) |-> $past(desc_valid, 2)
    ) else $error("decision without a descriptor two cycles earlier");

    ////////////////////////////////////////
    // Page pool

    // Pool must be non-empty and the count must drop by one on the next edge
    alloc_needs_free_page: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        alloc |-> (free_pages != '0) ##1 (free_pages == $past(free_pages) - 1'b1)
    ) else $error("page allocation with an empty pool or no count update");

endmodule

bind admission_ctrl cong_man_assertions ctrl_checks (
    .core_clk_ifc (core_clk_ifc),
    .reset        (reset),
    .desc_valid   (desc_valid),
    .enq_valid    (enq_valid),
    .drop_valid   (drop_valid),
    .alloc        (alloc),
    .free_pages   (free_pages)
);

// File: source/cong_man_top.sv
/* Congestion manager admission stage top level: state tables,
   page allocator and admission controller */

module cong_man_top (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    // Descriptor strobe
    input  logic                       desc_valid,
    input  cong_man_pkg::port_t        desc_port,
    input  cong_man_pkg::prio_t        desc_prio,
    input  cong_man_pkg::byte_len_t    desc_len,
    input  logic                       desc_drop_mark,
    // Drop threshold writes
    input  logic                       thresh_wr_en,
    input  cong_man_pkg::queue_idx_t   thresh_wr_queue,
    input  cong_man_pkg::occ_t         thresh_wr_data,
    // Decisions
    output logic                       enq_valid,
    output cong_man_pkg::queue_idx_t   enq_queue,
    output cong_man_pkg::word_ptr_t    enq_new_tail,
    output logic                       enq_malloc,
    output cong_man_pkg::page_idx_t    enq_page,
    output logic                       drop_valid,
    output cong_man_pkg::drop_reason_t drop_reason,
    output cong_man_pkg::page_cnt_t    num_free_pages
);
    import cong_man_pkg::*;

    logic      alloc;
    page_idx_t next_page;

    table_port_if #(.entry_t(occ_t))        occ_port ();
    table_port_if #(.entry_t(tail_entry_t)) tail_port ();
    table_port_if #(.entry_t(occ_t))        thresh_port ();

    ////////////////////////////////////////
    // Queue state tables

    queue_state_table #(
        .entry_t     (occ_t),
        .RESET_VALUE (occ_t'(0))
    ) occ_table (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .port         (occ_port.table_side)
    );

    // Empty queue, no page held
    queue_state_table #(
        .entry_t     (tail_entry_t),
        .RESET_VALUE (tail_entry_t'(0))
    ) tail_table (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .port         (tail_port.table_side)
    );

    // Thresholds default to the whole memory
    queue_state_table #(
        .entry_t     (occ_t),
        .RESET_VALUE (occ_t'(MEM_BYTES))
    ) thresh_table (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .port         (thresh_port.table_side)
    );

    assign thresh_port.wr_en   = thresh_wr_en;
    assign thresh_port.wr_idx  = thresh_wr_queue;
    assign thresh_port.wr_data = thresh_wr_data;

    ////////////////////////////////////////
    // Page pool and controller

    page_allocator page_alloc (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .alloc        (alloc),
        .next_page    (next_page),
        .free_pages   (num_free_pages)
    );

    admission_ctrl ctrl (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .desc_valid     (desc_valid),
        .desc_port      (desc_port),
        .desc_prio      (desc_prio),
        .desc_len       (desc_len),
        .desc_drop_mark (desc_drop_mark),
        .occ            (occ_port.user),
        .tail           (tail_port.user),
        .thresh         (thresh_port.user),
        .alloc          (alloc),
        .next_page      (next_page),
        .free_pages     (num_free_pages),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_new_tail   (enq_new_tail),
        .enq_malloc     (enq_malloc),
        .enq_page       (enq_page),
        .drop_valid     (drop_valid),
        .drop_reason    (drop_reason)
    );

endmodule

// File: source/admission_ctrl.sv
/* Admission controller: descriptor register stage, drop decision,
   queue table updates and page allocation requests */

`include "cong_man_cfg.svh"

module admission_ctrl (
    input  logic                       core_clk_ifc,
    input  logic                       reset,
    input  logic                       desc_valid,
    input  cong_man_pkg::port_t        desc_port,
    input  cong_man_pkg::prio_t        desc_prio,
    input  cong_man_pkg::byte_len_t    desc_len,
    input  logic                       desc_drop_mark,
    table_port_if.user                 occ,
    table_port_if.user                 tail,
    table_port_if.user                 thresh,
    output logic                       alloc,
    input  cong_man_pkg::page_idx_t    next_page,
    input  cong_man_pkg::page_cnt_t    free_pages,
    output logic                       enq_valid,
    output cong_man_pkg::queue_idx_t   enq_queue,
    output cong_man_pkg::word_ptr_t    enq_new_tail,
    output logic                       enq_malloc,
    output cong_man_pkg::page_idx_t    enq_page,
    output logic                       drop_valid,
    output cong_man_pkg::drop_reason_t drop_reason
);
    import cong_man_pkg::*;

    localparam int WORD_SHIFT = $clog2(`CM_WORD_BYTES);
    localparam int PAGE_SHIFT = $clog2(`CM_PAGE_BYTES);
    localparam int WORD_CNT_W = BYTE_LEN_W - WORD_SHIFT + 1;

    typedef logic [WORD_CNT_W-1:0] word_cnt_t;

    // Stage 1 registers
    logic       s1_valid;
    queue_idx_t s1_queue;
    prio_t      s1_prio;
    byte_len_t  s1_len;
    logic       s1_mark;
    word_cnt_t  s1_words;

    // Stage 2 decision
    logic [BYTE_LEN_W:0] len_round;
    logic                prio_hi;
    occ_t                cur_occ;
    occ_t                cur_thresh;
    tail_entry_t         cur_tail;
    tail_entry_t         new_tail;
    logic [OCC_W:0]      occ_sum;
    logic [WORD_CNT_W:0] tail_sum;
    occ_t                occ_pages;
    logic                need_malloc;
    logic                drop_hit;
    drop_reason_t        reason;
    logic                accept;

    ////////////////////////////////////////
    // Stage 1: queue mapping, word count

    assign len_round = {1'b0, desc_len} + (BYTE_LEN_W + 1)'(`CM_WORD_BYTES - 1);
    assign prio_hi   = (desc_prio >= prio_t'(`CM_PRIO_SPLIT));

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= desc_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (desc_valid) begin
            s1_queue <= queue_idx_t'(int'(desc_port) * `CM_QUEUES_PER_PORT + int'(prio_hi));
            s1_prio  <= desc_prio;
            s1_len   <= desc_len;
            s1_mark  <= desc_drop_mark;
            // Round up to whole memory words
            s1_words <= len_round[BYTE_LEN_W:WORD_SHIFT];
        end
    end

    ////////////////////////////////////////
    // Stage 2: table reads and drop rules

    assign occ.rd_idx    = s1_queue;
    assign tail.rd_idx   = s1_queue;
    assign thresh.rd_idx = s1_queue;

    assign cur_occ    = occ.rd_data;
    assign cur_tail   = tail.rd_data;
    assign cur_thresh = thresh.rd_data;

    assign occ_sum   = {1'b0, cur_occ} + (OCC_W + 1)'(s1_len);
    assign tail_sum  = (WORD_CNT_W + 1)'(cur_tail.tail_ptr) + {1'b0, s1_words};
    assign occ_pages = cur_occ >> PAGE_SHIFT;

    // No open page, or the packet runs to the end of it
    assign need_malloc = !cur_tail.page_valid || (tail_sum >= WORDS_PER_PAGE);

    // Checked in priority order, first match names the reason
    always_comb begin
        drop_hit = 1'b1;
        reason   = QUEUE_FULL;
        if (occ_sum > {1'b0, cur_thresh}) begin
            reason = QUEUE_FULL;
        end else if (s1_mark && (s1_prio < prio_t'(`CM_POLICER_PRIO))) begin
            reason = POLICER;
        end else if (need_malloc && (occ_pages > occ_t'(free_pages))) begin
            reason = OCC_EXCEEDS_FREE;
        end else if (need_malloc && (free_pages == '0)) begin
            reason = NO_PAGES;
        end else begin
            drop_hit = 1'b0;
        end
    end

    assign accept = s1_valid && !drop_hit;
    assign alloc  = accept && need_malloc;

    ////////////////////////////////////////
    // Table updates

    always_comb begin
        new_tail            = cur_tail;
        new_tail.tail_ptr   = tail_sum[WORD_PTR_W-1:0];
        if (need_malloc) begin
            new_tail.page       = next_page;
            new_tail.page_valid = 1'b1;
        end
    end

    assign occ.wr_en    = accept;
    assign occ.wr_idx   = s1_queue;
    assign occ.wr_data  = occ_sum[OCC_W-1:0];

    assign tail.wr_en   = accept;
    assign tail.wr_idx  = s1_queue;
    assign tail.wr_data = new_tail;

    ////////////////////////////////////////
    // Decision outputs

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            enq_valid  <= 1'b0;
            drop_valid <= 1'b0;
        end else begin
            enq_valid  <= accept;
            drop_valid <= s1_valid && drop_hit;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (s1_valid) begin
            enq_queue    <= s1_queue;
            enq_new_tail <= new_tail.tail_ptr;
            enq_malloc   <= need_malloc;
            enq_page     <= new_tail.page;
            drop_reason  <= reason;
        end
    end

endmodule

// File: source/page_allocator.sv
/* Page allocator: ascending page numbers from zero
   and a count of pages still free */

`include "cong_man_cfg.svh"

module page_allocator (
    input  logic                    core_clk_ifc,
    input  logic                    reset,
    input  logic                    alloc,
    output cong_man_pkg::page_idx_t next_page,
    output cong_man_pkg::page_cnt_t free_pages
);
    import cong_man_pkg::*;

    page_idx_t page_q;
    page_cnt_t free_q;

    ////////////////////////////////////////
    // Allocation state

    // Pages are never returned, so the pool only drains until reset
    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            page_q <= '0;
            free_q <= page_cnt_t'(`CM_NUM_PAGES);
        end else if (alloc) begin
            page_q <= page_q + page_idx_t'(1);
            free_q <= free_q - page_cnt_t'(1);
        end
    end

    ////////////////////////////////////////
    // Outputs

    // Page handed out on the next alloc
    assign next_page  = page_q;
    assign free_pages = free_q;

endmodule

// File: source/queue_state_table.sv
/* Per-queue register table with a combinational read port,
   one write port and a payload specific reset value */

module queue_state_table #(
    parameter type    entry_t     = logic,
    parameter entry_t RESET_VALUE = '0
) (
    input logic              core_clk_ifc,
    input logic              reset,
    table_port_if.table_side port
);
    import cong_man_pkg::*;

    entry_t entries [NUM_QUEUES];

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                entries[i] <= RESET_VALUE;
            end
        end else if (port.wr_en) begin
            entries[port.wr_idx] <= port.wr_data;
        end
    end

    ////////////////////////////////////////
    // Read side

    // Same cycle writes are not bypassed
    assign port.rd_data = entries[port.rd_idx];

endmodule

// File: source/table_port_if.sv
/* Read and write port of one per-queue state table */

interface table_port_if #(
    parameter type entry_t = logic
);
    import cong_man_pkg::*;

    // Combinational read
    queue_idx_t rd_idx;
    entry_t     rd_data;

    // Write lands on the clock edge
    logic       wr_en;
    queue_idx_t wr_idx;
    entry_t     wr_data;

    modport table_side (
        input  rd_idx, wr_en, wr_idx, wr_data,
        output rd_data
    );

    modport user (
        output rd_idx, wr_en, wr_idx, wr_data,
        input  rd_data
    );

endinterface

// File: source/cong_man_pkg.sv
/* Widths, table entry types and the drop reason encoding */

`include "cong_man_cfg.svh"

package cong_man_pkg;

    localparam int NUM_QUEUES     = `CM_NUM_EGR_PORTS * `CM_QUEUES_PER_PORT;
    localparam int WORDS_PER_PAGE = `CM_PAGE_BYTES / `CM_WORD_BYTES;
    localparam int MEM_BYTES      = `CM_NUM_PAGES * `CM_PAGE_BYTES;

    localparam int QUEUE_W    = $clog2(NUM_QUEUES);
    localparam int PAGE_W     = $clog2(`CM_NUM_PAGES);
    localparam int PAGE_CNT_W = $clog2(`CM_NUM_PAGES + 1);
    localparam int WORD_PTR_W = $clog2(WORDS_PER_PAGE);
    localparam int BYTE_LEN_W = $clog2(`CM_MTU_BYTES + 1);
    localparam int PRIO_W     = 3;
    localparam int PORT_W     = $clog2(`CM_NUM_EGR_PORTS);
    // Headroom above the memory size so run time thresholds are not clipped
    localparam int OCC_W      = 20;

    typedef logic [QUEUE_W-1:0]    queue_idx_t;
    typedef logic [PAGE_W-1:0]     page_idx_t;
    typedef logic [PAGE_CNT_W-1:0] page_cnt_t;
    typedef logic [WORD_PTR_W-1:0] word_ptr_t;
    typedef logic [BYTE_LEN_W-1:0] byte_len_t;
    typedef logic [PRIO_W-1:0]     prio_t;
    typedef logic [PORT_W-1:0]     port_t;
    typedef logic [OCC_W-1:0]      occ_t;

    // Write position of a queue inside its current page
    typedef struct packed {
        word_ptr_t tail_ptr;
        page_idx_t page;
        logic      page_valid;
    } tail_entry_t;

    typedef enum logic [1:0] {
        QUEUE_FULL       = 2'd0,
        POLICER          = 2'd1,
        OCC_EXCEEDS_FREE = 2'd2,
        NO_PAGES         = 2'd3
    } drop_reason_t;

endpackage

// File: source/cong_man_cfg.svh
/* Sizing macros for the congestion manager admission stage:
   port and queue counts, priority rules, memory geometry and MTU */

`ifndef CONG_MAN_CFG_SVH
`define CONG_MAN_CFG_SVH

// Egress side
`define CM_NUM_EGR_PORTS    4
`define CM_QUEUES_PER_PORT  2

// Priority at or above this selects the second queue of a port
`define CM_PRIO_SPLIT       5

// Policer marked packets below this priority are dropped
`define CM_POLICER_PRIO     6

// Packet memory geometry
`define CM_WORD_BYTES       64
`define CM_PAGE_BYTES       1024
`define CM_NUM_PAGES        64

`define CM_MTU_BYTES        1500

`endif
